// ==== common/max6682Pkg.sv ====
package max6682Pkg;

  // ----------------------------------------------------------
  // Frame and temperature format.
  // ----------------------------------------------------------
  localparam int ByteWidth  = 8;
  localparam int FrameWidth = 2 * ByteWidth;
  localparam int TempWidth  = 11;                    // Signed, 0.125 degree steps.
  localparam int TempLsbPos = 5;                     // Frame bits 15 to 5 hold the reading.

  // ----------------------------------------------------------
  // Timing.
  // ----------------------------------------------------------
  localparam int SclkHalfPeriod = 4;                 // System clocks per SCLK half period.
  localparam int SamplePeriod   = 600;               // System clocks between sample requests.

  localparam int HalfCntWidth   = $clog2(SclkHalfPeriod);
  localparam int BitCntWidth    = $clog2(ByteWidth);
  localparam int SampleCntWidth = $clog2(SamplePeriod);

  typedef logic [ByteWidth-1:0] spiByteT;
  typedef logic signed [TempWidth-1:0] tempT;

  typedef enum logic [2:0]
  {
    Idle,
    Write1,
    Write2,
    Wait,
    Read1,
    Read2
  } fsmStateT;

endpackage

// ==== common/spiByteIf.sv ====
interface spiByteIf;
  import max6682Pkg::*;

  logic    write;                                    // One cycle push into the TX queue.
  spiByteT txData;
  logic    readNext;                                 // One cycle pop of the RX queue.
  spiByteT rxData;                                   // Head of the RX queue.
  logic    transmission;                             // A byte is queued or shifting.

  modport ctrl
  (
    output write,
    output txData,
    output readNext,
    input  rxData,
    input  transmission
  );

  modport engine
  (
    input  write,
    input  txData,
    input  readNext,
    output rxData,
    output transmission
  );

endinterface

// ==== hw/spiMaster/spiMaster.sv ====
module spiMaster (
  input  logic     Clk_i,
  input  logic     rst_i,
  spiByteIf.engine spi,
  input  logic     miso_i,
  output logic     sclk_o,
  output logic     mosi_o
);
  import max6682Pkg::*;

  spiByteT                 txQueue [2];
  logic                    txWrPtr;
  logic                    txRdPtr;
  logic [1:0]              txCount;
  logic                    txPush;
  logic                    txPop;

  spiByteT                 rxQueue [2];
  logic                    rxWrPtr;
  logic                    rxRdPtr;
  logic [1:0]              rxCount;
  logic                    rxPush;
  logic                    rxPop;

  logic                    busy;
  logic                    sclkReg;
  logic [HalfCntWidth-1:0] halfCnt;
  logic [BitCntWidth-1:0]  bitCnt;
  spiByteT                 shiftReg;
  logic                    misoBit;
  logic                    halfEnd;
  logic                    byteEnd;
  logic                    loadByte;
  spiByteT                 nextByte;

  // ----------------------------------------------------------
  // Queue control.
  // ----------------------------------------------------------
  assign halfEnd  = busy && (halfCnt == HalfCntWidth'(SclkHalfPeriod - 1));
  assign byteEnd  = halfEnd && sclkReg && (bitCnt == BitCntWidth'(ByteWidth - 1));
  assign loadByte = (!busy || byteEnd) && ((txCount != 2'd0) || spi.write);

  // An empty queue lets a pushed byte go straight into the shifter.
  assign nextByte = (txCount != 2'd0) ? txQueue[txRdPtr] : spi.txData;
  assign txPop    = loadByte && (txCount != 2'd0);
  assign txPush   = spi.write && !(loadByte && (txCount == 2'd0));

  assign rxPush   = byteEnd;
  assign rxPop    = spi.readNext && (rxCount != 2'd0);

  assign spi.rxData       = rxQueue[rxRdPtr];
  assign spi.transmission = busy || (txCount != 2'd0);

  always_ff @(posedge Clk_i)
  begin
    if (txPush)
    begin
      txQueue[txWrPtr] <= spi.txData;
    end
    if (rxPush)
    begin
      rxQueue[rxWrPtr] <= {shiftReg[ByteWidth-2:0], misoBit};
    end
  end

  always_ff @(posedge Clk_i)
  begin
    if (rst_i)
    begin
      txWrPtr <= 1'b0;
      txRdPtr <= 1'b0;
      txCount <= 2'd0;
      rxWrPtr <= 1'b0;
      rxRdPtr <= 1'b0;
      rxCount <= 2'd0;
    end
    else
    begin
      if (txPush)
      begin
        txWrPtr <= ~txWrPtr;
      end
      if (txPop)
      begin
        txRdPtr <= ~txRdPtr;
      end
      if (rxPush)
      begin
        rxWrPtr <= ~rxWrPtr;
      end
      if (rxPop)
      begin
        rxRdPtr <= ~rxRdPtr;
      end
      txCount <= txCount + {1'b0, txPush} - {1'b0, txPop};
      rxCount <= rxCount + {1'b0, rxPush} - {1'b0, rxPop};
    end
  end

  // ----------------------------------------------------------
  // Shift engine, mode 0, MSB first.
  // ----------------------------------------------------------
  always_ff @(posedge Clk_i)
  begin
    if (rst_i)
    begin
      busy    <= 1'b0;
      sclkReg <= 1'b0;
      halfCnt <= '0;
      bitCnt  <= '0;
    end
    else if (loadByte)
    begin
      busy    <= 1'b1;
      sclkReg <= 1'b0;
      halfCnt <= '0;
      bitCnt  <= '0;
    end
    else if (byteEnd)
    begin
      busy    <= 1'b0;
      sclkReg <= 1'b0;
    end
    else if (halfEnd)
    begin
      sclkReg <= ~sclkReg;
      halfCnt <= '0;
      if (sclkReg)
      begin
        bitCnt <= bitCnt + 1'b1;                     // Falling edge ends a bit.
      end
    end
    else if (busy)
    begin
      halfCnt <= halfCnt + 1'b1;
    end
  end

  always_ff @(posedge Clk_i)
  begin
    if (loadByte)
    begin
      shiftReg <= nextByte;
    end
    else if (halfEnd && sclkReg)
    begin
      shiftReg <= {shiftReg[ByteWidth-2:0], misoBit}; // MOSI moves on the falling edge.
    end
    if (halfEnd && !sclkReg)
    begin
      misoBit <= miso_i;                             // Sample on the rising edge.
    end
  end

  assign sclk_o = sclkReg;
  assign mosi_o = busy && shiftReg[ByteWidth-1];

endmodule

// ==== hw/max6682Fsm.sv ====
module max6682Fsm (
  input  logic                Clk_i,
  input  logic                rst_i,
  input  logic                start_i,
  spiByteIf.ctrl              spi,
  output logic                csN_o,
  output logic                done_o,
  output max6682Pkg::spiByteT byteHigh_o,
  output max6682Pkg::spiByteT byteLow_o
);
  import max6682Pkg::*;

  fsmStateT state;
  fsmStateT nextState;
  logic     captureHigh;
  logic     captureLow;

  always_ff @(posedge Clk_i)
  begin
    if (rst_i)
    begin
      state <= Idle;
    end
    else
    begin
      state <= nextState;
    end
  end

  // ----------------------------------------------------------
  // Frame sequence.
  // ----------------------------------------------------------
  always_comb
  begin
    nextState    = state;
    csN_o        = 1'b1;
    spi.write    = 1'b0;
    spi.readNext = 1'b0;
    captureHigh  = 1'b0;
    captureLow   = 1'b0;
    done_o       = 1'b0;
    case (state)
      Idle:
      begin
        if (start_i)
        begin
          nextState = Write1;
          csN_o     = 1'b0;
          spi.write = 1'b1;
        end
      end
      Write1:
      begin
        nextState = Write2;
        csN_o     = 1'b0;
        spi.write = 1'b1;
      end
      Write2:
      begin
        nextState = Wait;
        csN_o     = 1'b0;
      end
      Wait:
      begin
        csN_o = 1'b0;
        if (!spi.transmission)
        begin
          nextState    = Read1;
          spi.readNext = 1'b1;
          captureHigh  = 1'b1;
        end
      end
      Read1:
      begin
        nextState    = Read2;
        csN_o        = 1'b0;
        spi.readNext = 1'b1;
        captureLow   = 1'b1;
      end
      Read2:
      begin
        done_o = 1'b1;
        if (start_i)
        begin
          nextState = Write1;                        // Back to back frame.
          csN_o     = 1'b0;
          spi.write = 1'b1;
        end
        else
        begin
          nextState = Idle;
        end
      end
      default:
      begin
        nextState = Idle;
      end
    endcase
  end

  assign spi.txData = '0;                            // The sensor ignores MOSI.

  always_ff @(posedge Clk_i)
  begin
    if (captureHigh)
    begin
      byteHigh_o <= spi.rxData;
    end
    if (captureLow)
    begin
      byteLow_o <= spi.rxData;
    end
  end

endmodule

// ==== hw/tempMonitor.sv ====
module tempMonitor (
  input  logic                Clk_i,
  input  logic                rst_i,
  input  logic                enable_i,
  input  max6682Pkg::tempT    threshold_i,
  input  logic                done_i,
  input  max6682Pkg::spiByteT byteHigh_i,
  input  max6682Pkg::spiByteT byteLow_i,
  output logic                start_o,
  output max6682Pkg::tempT    temp_o,
  output logic                tempValid_o,
  output logic                alarm_o
);
  import max6682Pkg::*;

  logic [SampleCntWidth-1:0] timer;
  logic                      tick;
  logic                      request;
  logic [FrameWidth-1:0]     frame;
  tempT                      newTemp;

  // ----------------------------------------------------------
  // Sample interval and request.
  // ----------------------------------------------------------
  assign tick = enable_i && (timer == SampleCntWidth'(SamplePeriod - 1));

  always_ff @(posedge Clk_i)
  begin
    if (rst_i || !enable_i || tick)
    begin
      timer <= '0;
    end
    else
    begin
      timer <= timer + 1'b1;
    end
  end

  // Start drops in the done cycle so the FSM returns to Idle.
  assign start_o = request && !done_i;

  // ----------------------------------------------------------
  // Reading and alarm.
  // ----------------------------------------------------------
  assign frame   = {byteHigh_i, byteLow_i};
  assign newTemp = frame[FrameWidth-1:TempLsbPos];   // Low five frame bits are dropped.

  always_ff @(posedge Clk_i)
  begin
    if (rst_i)
    begin
      request     <= 1'b0;
      tempValid_o <= 1'b0;
      alarm_o     <= 1'b0;
    end
    else
    begin
      request     <= tick || (request && !done_i);   // A tick while pending merges.
      tempValid_o <= done_i;
      if (done_i)
      begin
        alarm_o <= newTemp > threshold_i;            // Both operands are signed.
      end
    end
  end

  always_ff @(posedge Clk_i)
  begin
    if (done_i)
    begin
      temp_o <= newTemp;
    end
  end

endmodule

// ==== hw/max6682Reader.sv ====
module max6682Reader (
  input  logic             Clk_i,
  input  logic             rst_i,
  input  logic             enable_i,
  input  max6682Pkg::tempT threshold_i,
  input  logic             miso_i,
  output logic             csN_o,
  output logic             sclk_o,
  output logic             mosi_o,
  output max6682Pkg::tempT temp_o,
  output logic             tempValid_o,
  output logic             alarm_o
);
  import max6682Pkg::*;

  logic    frameStart;
  logic    frameDone;
  spiByteT byteHigh;
  spiByteT byteLow;

  spiByteIf spiBus ();

  spiMaster spiMasterInst (
    .Clk_i  (Clk_i),
    .rst_i  (rst_i),
    .spi    (spiBus.engine),
    .miso_i (miso_i),
    .sclk_o (sclk_o),
    .mosi_o (mosi_o)
  );

  max6682Fsm fsmInst (
    .Clk_i      (Clk_i),
    .rst_i      (rst_i),
    .start_i    (frameStart),
    .spi        (spiBus.ctrl),
    .csN_o      (csN_o),
    .done_o     (frameDone),
    .byteHigh_o (byteHigh),
    .byteLow_o  (byteLow)
  );

  tempMonitor monitorInst (
    .Clk_i       (Clk_i),
    .rst_i       (rst_i),
    .enable_i    (enable_i),
    .threshold_i (threshold_i),
    .done_i      (frameDone),
    .byteHigh_i  (byteHigh),
    .byteLow_i   (byteLow),
    .start_o     (frameStart),
    .temp_o      (temp_o),
    .tempValid_o (tempValid_o),
    .alarm_o     (alarm_o)
  );

endmodule

// ==== testbench/max6682Model.sv ====
module max6682Model (
  input  logic        Clk_i,
  input  logic        csN_i,
  input  logic        sclk_i,
  input  logic        mosi_i,
  input  logic [15:0] frame_i,
  output logic        miso_o,
  output int          sclkEdges_o,
  output logic        mosiSeen_o
);

  logic misoBit   = 1'b0;
  int   edgeCount = 0;
  logic mosiHigh  = 1'b0;
  logic prevCsN   = 1'b1;
  logic prevSclk  = 1'b0;
  int   bitPos    = 14;

  assign miso_o      = misoBit;
  assign sclkEdges_o = edgeCount;
  assign mosiSeen_o  = mosiHigh;

  always @(posedge Clk_i)
  begin
    if (csN_i)
    begin
      misoBit <= frame_i[15];                        // Bit 15 waits on MISO for the frame.
      bitPos  <= 14;
    end
    else
    begin
      if (prevCsN)
      begin
        edgeCount <= 0;                              // A new low window of chip select.
        mosiHigh  <= mosi_i;
      end
      else
      begin
        if (sclk_i && !prevSclk)
        begin
          edgeCount <= edgeCount + 1;
        end
        if (mosi_i)
        begin
          mosiHigh <= 1'b1;
        end
      end
      if (!sclk_i && prevSclk && (bitPos >= 0))
      begin
        misoBit <= frame_i[bitPos];                  // Next bit after a falling SCLK.
        bitPos  <= bitPos - 1;
      end
    end
    prevCsN  <= csN_i;
    prevSclk <= sclk_i;
  end

endmodule

// ==== testbench/max6682Checker.sv ====
module max6682Checker (
  input logic             Clk_i,
  input logic             rst_i,
  input logic             enable_i,
  input logic             csN_i,
  input logic             sclk_i,
  input logic             mosi_i,
  input max6682Pkg::tempT temp_i,
  input logic             tempValid_i,
  input logic             alarm_i,
  input int               sclkEdges_i,
  input logic             mosiSeen_i
);
  import max6682Pkg::*;

  localparam int EdgesPerFrame = 2 * ByteWidth;
  localparam int QuietCycles   = 2 * SamplePeriod;

  tempT expTemp [$];
  logic expAlarm [$];
  int   passCount  = 0;
  int   failCount  = 0;
  int   errorCount = 0;
  int   testNum    = 0;
  int   testErrors = 0;
  int   framesSeen = 0;
  int   quietCount = 0;
  logic prevRst    = 1'b0;
  logic prevCsN    = 1'b1;

  task automatic pushExpected(input tempT temp, input logic alarm);
    expTemp.push_back(temp);
    expAlarm.push_back(alarm);
  endtask

  task automatic compareValue(input string name, input logic signed [31:0] expected,
                              input logic signed [31:0] actual);
    if (actual !== expected)
    begin
      $display("ERROR at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
      errorCount++;
      testErrors++;
    end
  endtask

  task automatic flagEvent(input string what);
    $display("Failure at %0t: %s", $time, what);
    errorCount++;
    testErrors++;
  endtask

  task automatic closeTest(input string label);
    testNum++;
    if (testErrors == 0)
    begin
      passCount++;
      $display("Test %0d, %s: pass", testNum, label);
    end
    else
    begin
      failCount++;
      $display("Test %0d, %s: fail with %0d errors", testNum, label, testErrors);
    end
    testErrors = 0;
  endtask

  task automatic checkReading();
    tempT wantTemp;
    logic wantAlarm;
    if (framesSeen != 1)
    begin
      flagEvent($sformatf("%0d SPI frames came before this reading", framesSeen));
    end
    framesSeen = 0;
    if (expTemp.size() == 0)
    begin
      flagEvent("tempValid_o pulsed while no reading was expected");
      closeTest("unexpected reading");
    end
    else
    begin
      wantTemp  = expTemp.pop_front();
      wantAlarm = expAlarm.pop_front();
      compareValue("temp_o", wantTemp, temp_i);
      compareValue("alarm_o", wantAlarm, alarm_i);
      closeTest($sformatf("reading of %0d", wantTemp));
    end
  endtask

  // ----------------------------------------------------------
  // Sampled on the rising clock, where driven inputs are settled.
  // ----------------------------------------------------------
  always @(posedge Clk_i)
  begin
    if (prevRst)
    begin
      compareValue("csN_o", 1, csN_i);               // Idle during reset and just after.
      compareValue("sclk_o", 0, sclk_i);
      compareValue("mosi_o", 0, mosi_i);
      compareValue("tempValid_o", 0, tempValid_i);
      compareValue("alarm_o", 0, alarm_i);
      if (!rst_i)
      begin
        closeTest("reset");
      end
    end
    else if (!rst_i)
    begin
      if (csN_i && !prevCsN)
      begin
        framesSeen++;                                // Chip select just rose.
        compareValue("SCLK rising edges", EdgesPerFrame, sclkEdges_i);
        compareValue("mosi_o during frame", 0, mosiSeen_i);
      end
      if (tempValid_i)
      begin
        checkReading();
      end
      if (!enable_i)
      begin
        quietCount++;
        if (testErrors == 0)
        begin
          compareValue("csN_o", 1, csN_i);
          compareValue("tempValid_o", 0, tempValid_i);
        end
      end
      else if (quietCount > 0)
      begin
        if (quietCount < QuietCycles)
        begin
          flagEvent("enable_i was low for less than two sample periods");
        end
        closeTest("enable low");
        quietCount = 0;
      end
    end
    prevRst = rst_i;
    prevCsN = csN_i;
  end

endmodule

// ==== testbench/max6682ReaderTb.sv ====
module max6682ReaderTb;
  import max6682Pkg::*;

  localparam int ClkPeriod     = 100;
  localparam int ResetCycles   = 5;
  localparam int NumTests      = 10;
  localparam int TimeoutCycles = NumTests * (SamplePeriod + 100 * SclkHalfPeriod);

  typedef struct packed
  {
    tempT       temp;
    tempT       threshold;
    logic       alarm;                               // Expected alarm for the reading.
    logic       enable;
    logic [8:0] holdOff;                             // Clocks to wait before the entry.
  } stimT;

  // Temperature, threshold, expected alarm, enable, hold-off.
  stimT stimTable [NumTests] = '{
    '{ 11'sd200,   11'sd100,  1'b1, 1'b1, 9'd0   },
    '{ 11'sd100,   11'sd100,  1'b0, 1'b1, 9'd50  },
    '{ 11'sd101,   11'sd100,  1'b1, 1'b1, 9'd120 },
    '{ -11'sd40,   -11'sd50,  1'b1, 1'b1, 9'd10  },
    '{ -11'sd50,   -11'sd50,  1'b0, 1'b1, 9'd300 },
    '{ 11'sd0,     11'sd0,    1'b0, 1'b0, 9'd0   },
    '{ 11'sh400,   11'sd0,    1'b0, 1'b1, 9'd0   },
    '{ 11'sd1023,  11'sd1022, 1'b1, 1'b1, 9'd200 },
    '{ -11'sd1,    -11'sd2,   1'b1, 1'b1, 9'd30  },
    '{ 11'sd0,     11'sd0,    1'b0, 1'b1, 9'd80  }
  };

  logic                  clk;
  logic                  rst;
  logic                  enable;
  tempT                  threshold;
  logic                  miso;
  logic                  csN;
  logic                  sclk;
  logic                  mosi;
  tempT                  temp;
  logic                  tempValid;
  logic                  alarm;
  logic [FrameWidth-1:0] frame;
  int                    sclkEdges;
  logic                  mosiSeen;
  tempT                  entryTemp;
  tempT                  entryThreshold;
  logic [TempLsbPos-1:0] lowBits;
  int                    idx;

  max6682Reader dut (
    .Clk_i       (clk),
    .rst_i       (rst),
    .enable_i    (enable),
    .threshold_i (threshold),
    .miso_i      (miso),
    .csN_o       (csN),
    .sclk_o      (sclk),
    .mosi_o      (mosi),
    .temp_o      (temp),
    .tempValid_o (tempValid),
    .alarm_o     (alarm)
  );

  max6682Model sensor (
    .Clk_i       (clk),
    .csN_i       (csN),
    .sclk_i      (sclk),
    .mosi_i      (mosi),
    .frame_i     (frame),
    .miso_o      (miso),
    .sclkEdges_o (sclkEdges),
    .mosiSeen_o  (mosiSeen)
  );

  max6682Checker scoreboard (
    .Clk_i       (clk),
    .rst_i       (rst),
    .enable_i    (enable),
    .csN_i       (csN),
    .sclk_i      (sclk),
    .mosi_i      (mosi),
    .temp_i      (temp),
    .tempValid_i (tempValid),
    .alarm_i     (alarm),
    .sclkEdges_i (sclkEdges),
    .mosiSeen_i  (mosiSeen)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  // ----------------------------------------------------------
  // Stimulus, driven on the falling clock edge.
  // ----------------------------------------------------------
  initial
  begin
    void'($urandom(32'hd062f5df));
    clk       = 1'b0;
    rst       = 1'b1;
    enable    = 1'b1;
    threshold = '0;
    frame     = '0;
    repeat (ResetCycles) @(negedge clk);
    rst = 1'b0;
    for (idx = 0; idx < NumTests; idx++)
    begin
      repeat (stimTable[idx].holdOff + 1) @(negedge clk);
      entryTemp      = stimTable[idx].temp;
      entryThreshold = stimTable[idx].threshold;
      lowBits        = TempLsbPos'($urandom);       // Noise below the reading.
      frame          = {entryTemp, lowBits};
      threshold      = entryThreshold;
      enable         = stimTable[idx].enable;
      if (enable)
      begin
        scoreboard.pushExpected(entryTemp, stimTable[idx].alarm);
        @(negedge clk);
        while (!tempValid)
        begin
          @(negedge clk);
        end
      end
      else
      begin
        repeat (2 * SamplePeriod) @(negedge clk);
      end
    end
    repeat (4) @(negedge clk);
    $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
             scoreboard.passCount, scoreboard.failCount, scoreboard.errorCount);
    if ((scoreboard.failCount == 0) && (scoreboard.errorCount == 0) &&
        (scoreboard.passCount == NumTests + 1))
    begin
      $display("TESTS PASSED");
    end
    else
    begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial
  begin
    #((TimeoutCycles + ResetCycles) * ClkPeriod);
    $display("Timeout: the readings did not finish within %0d clock cycles.", TimeoutCycles);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// ==== filelist.f ====
common/max6682Pkg.sv
common/spiByteIf.sv
hw/spiMaster/spiMaster.sv
hw/max6682Fsm.sv
hw/tempMonitor.sv
hw/max6682Reader.sv
testbench/max6682Model.sv
testbench/max6682Checker.sv
testbench/max6682ReaderTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module max6682ReaderTb -f filelist.f
simOutput=$(./obj_dir/Vmax6682ReaderTb)
echo "$simOutput"

if echo "$simOutput" | grep -qx "TESTS PASSED"
then
  exit 0
fi
exit 1
